//--- logic/rvx_pkg.sv
package rvx_pkg;

    ////////////////////////////////////////////////////////////
    // cluster sizing
    ////////////////////////////////////////////////////////////

    // datapath and tag widths
    localparam int xlen = 32;
    localparam int tag_w = 8;

    // lane layout
    localparam int lane_count = 4;
    localparam int lane_depth = 2;
    // one credit per fifo entry plus the result register
    localparam int lane_credits = lane_depth + 1;

    // counter and pointer widths
    localparam int credit_w = $clog2(lane_credits + 1);
    localparam int lane_idx_w = $clog2(lane_count);
    localparam int lane_ptr_w = $clog2(lane_depth);
    localparam int lane_cnt_w = $clog2(lane_depth + 1);

    typedef logic [credit_w-1:0] credit_t;
    typedef logic [lane_idx_w-1:0] lane_idx_t;
    typedef logic [lane_ptr_w-1:0] lane_ptr_t;
    typedef logic [lane_cnt_w-1:0] lane_cnt_t;
    // one bit per lane
    typedef logic [lane_count-1:0] lane_mask_t;

    ////////////////////////////////////////////////////////////
    // rv32i encodings
    ////////////////////////////////////////////////////////////

    // major opcodes handled by the lanes
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // funct3 values of the alu group
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_sr = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fields;

    // register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_i_fields;

    // same word, view picked by opcode
    typedef union packed {
        rv_r_fields r;
        rv_i_fields i;
    } rv_insn_u;

    ////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////

    // host to lane
    typedef struct packed {
        logic [tag_w-1:0] tag;
        rv_insn_u insn;
        logic [xlen-1:0] rs1_val;
        // unused for op-imm
        logic [xlen-1:0] rs2_val;
    } issue_pkt_t;

    // lane to host
    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0] value;
        logic illegal;
    } result_pkt_t;

endpackage

//--- logic/rvx_dispatch.sv
`timescale 1ns/1ps

module rvx_dispatch (
    input  logic clk,
    input  logic arst_n,

    // host side
    input  logic in_valid,
    output logic in_ready,
    input  rvx_pkg::issue_pkt_t in_pkt,

    // lane fifo write side
    output rvx_pkg::lane_mask_t lane_push,
    output rvx_pkg::issue_pkt_t lane_pkt,

    // pulses from the collector
    input  rvx_pkg::lane_mask_t credit_ret
);

    ////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////

    // free slots per lane
    rvx_pkg::credit_t credit [rvx_pkg::lane_count];
    // lane whose turn it is
    rvx_pkg::lane_idx_t issue_ptr;
    logic accept;

    ////////////////////////////////////////////////////////////
    // issue
    ////////////////////////////////////////////////////////////

    // only the turn lane counts, no skipping ahead
    assign in_ready = (credit[issue_ptr] != '0);
    assign accept = in_valid && in_ready;

    // packet goes straight to the fifo write port
    assign lane_pkt = in_pkt;

    always_comb begin
        for (int i = 0; i < rvx_pkg::lane_count; i++) begin
            lane_push[i] = accept && (int'(issue_ptr) == i);
        end
    end

    // pointer moves only on an accepted packet
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_ptr <= '0;
        end else if (accept) begin
            if (issue_ptr == rvx_pkg::lane_idx_t'(rvx_pkg::lane_count - 1)) begin
                issue_ptr <= '0;
            end else begin
                issue_ptr <= issue_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // credit counters
    ////////////////////////////////////////////////////////////

    // push spends one, return gives one back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rvx_pkg::lane_count; i++) begin
                credit[i] <= rvx_pkg::credit_t'(rvx_pkg::lane_credits);
            end
        end else begin
            for (int i = 0; i < rvx_pkg::lane_count; i++) begin
                case ({lane_push[i], credit_ret[i]})
                    2'b10: credit[i] <= credit[i] - 1'b1;
                    2'b01: credit[i] <= credit[i] + 1'b1;
                    // both or neither leaves the count alone
                    default: credit[i] <= credit[i];
                endcase
            end
        end
    end

endmodule

//--- logic/rvx_alu_lane.sv
`timescale 1ns/1ps

module rvx_alu_lane (
    input  logic clk,
    input  logic arst_n,

    // from the dispatcher
    input  logic push,
    input  rvx_pkg::issue_pkt_t pkt,

    // result register towards the collector
    output logic res_valid,
    output rvx_pkg::result_pkt_t res,
    input  logic pop
);

    ////////////////////////////////////////////////////////////
    // operand fifo
    ////////////////////////////////////////////////////////////

    rvx_pkg::issue_pkt_t fifo_mem [rvx_pkg::lane_depth];
    rvx_pkg::lane_ptr_t wr_ptr;
    rvx_pkg::lane_ptr_t rd_ptr;
    rvx_pkg::lane_cnt_t fifo_cnt;

    // head executes when the result slot frees up this cycle
    logic issue;
    rvx_pkg::issue_pkt_t head;

    assign head = fifo_mem[rd_ptr];
    assign issue = (fifo_cnt != '0) && (!res_valid || pop);

    // fifo storage
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= pkt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == rvx_pkg::lane_ptr_t'(rvx_pkg::lane_depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (issue) begin
                if (rd_ptr == rvx_pkg::lane_ptr_t'(rvx_pkg::lane_depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // space is guaranteed by the credits upstream
            case ({push, issue})
                2'b10: fifo_cnt <= fifo_cnt + 1'b1;
                2'b01: fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    logic is_op;
    logic is_imm;
    logic alt;
    logic [2:0] funct3;
    logic [rvx_pkg::xlen-1:0] op_a;
    logic [rvx_pkg::xlen-1:0] op_b;
    logic [4:0] shamt;
    logic [rvx_pkg::xlen-1:0] alu_val;

    // opcode and funct3 sit in the same bits in both views
    assign is_op = (head.insn.r.opcode == rvx_pkg::opc_op);
    assign is_imm = (head.insn.i.opcode == rvx_pkg::opc_op_imm);
    assign funct3 = head.insn.r.funct3;
    // instruction bit 30
    assign alt = head.insn.r.funct7[5];

    assign op_a = head.rs1_val;
    // sign-extended imm12 for the op-imm form
    assign op_b = is_imm ? {{(rvx_pkg::xlen - 12){head.insn.i.imm12[11]}}, head.insn.i.imm12}
                         : head.rs2_val;
    assign shamt = op_b[4:0];

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            // bit 30 means sub only for the register form
            rvx_pkg::f3_add: alu_val = (is_op && alt) ? op_a - op_b : op_a + op_b;
            rvx_pkg::f3_sll: alu_val = op_a << shamt;
            rvx_pkg::f3_slt: alu_val = {31'd0, $signed(op_a) < $signed(op_b)};
            rvx_pkg::f3_sltu: alu_val = {31'd0, op_a < op_b};
            rvx_pkg::f3_xor: alu_val = op_a ^ op_b;
            // bit 30 picks arithmetic shift in both forms
            rvx_pkg::f3_sr: alu_val = alt ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
            rvx_pkg::f3_or: alu_val = op_a | op_b;
            rvx_pkg::f3_and: alu_val = op_a & op_b;
            default: alu_val = '0;
        endcase
    end

    // result register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else if (issue) begin
            res_valid <= 1'b1;
        end else if (pop) begin
            res_valid <= 1'b0;
        end
    end

    // payload follows the valid bit
    always_ff @(posedge clk) begin
        if (issue) begin
            res.tag <= head.tag;
            // anything outside op and op-imm comes back as zero
            res.value <= (is_op || is_imm) ? alu_val : '0;
            res.illegal <= !(is_op || is_imm);
        end
    end

endmodule

//--- logic/rvx_collect.sv
`timescale 1ns/1ps

module rvx_collect (
    input  logic clk,
    input  logic arst_n,

    // lane result registers
    input  rvx_pkg::lane_mask_t lane_res_valid,
    input  rvx_pkg::result_pkt_t [rvx_pkg::lane_count-1:0] lane_res,
    output rvx_pkg::lane_mask_t lane_pop,

    // back to the dispatcher
    output rvx_pkg::lane_mask_t credit_ret,

    // host side
    output logic out_valid,
    input  logic out_ready,
    output rvx_pkg::result_pkt_t out_pkt
);

    ////////////////////////////////////////////////////////////
    // drain control
    ////////////////////////////////////////////////////////////

    // same lane order as the dispatcher
    rvx_pkg::lane_idx_t drain_ptr;
    rvx_pkg::lane_mask_t pop_mask;
    logic load;

    // output register empty or being taken
    assign load = lane_res_valid[drain_ptr] && (!out_valid || out_ready);

    always_comb begin
        for (int i = 0; i < rvx_pkg::lane_count; i++) begin
            pop_mask[i] = load && (int'(drain_ptr) == i);
        end
    end

    // popping the result register frees one lane credit
    assign lane_pop = pop_mask;
    assign credit_ret = pop_mask;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drain_ptr <= '0;
        end else if (load) begin
            // wait on the turn lane, keeps program order
            if (drain_ptr == rvx_pkg::lane_idx_t'(rvx_pkg::lane_count - 1)) begin
                drain_ptr <= '0;
            end else begin
                drain_ptr <= drain_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // holds until the host takes it
    always_ff @(posedge clk) begin
        if (load) begin
            out_pkt <= lane_res[drain_ptr];
        end
    end

endmodule

//--- logic/rvx_cluster_top.sv
`timescale 1ns/1ps

module rvx_cluster_top (
    input  logic clk,
    input  logic arst_n,

    // instruction input
    input  logic in_valid,
    output logic in_ready,
    input  rvx_pkg::issue_pkt_t in_pkt,

    // result output
    output logic out_valid,
    input  logic out_ready,
    output rvx_pkg::result_pkt_t out_pkt
);

    ////////////////////////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////////////////////////

    // dispatcher to lanes
    rvx_pkg::lane_mask_t lane_push;
    rvx_pkg::issue_pkt_t lane_pkt;

    // lanes to collector
    rvx_pkg::lane_mask_t lane_res_valid;
    rvx_pkg::result_pkt_t [rvx_pkg::lane_count-1:0] lane_res;
    rvx_pkg::lane_mask_t lane_pop;

    // collector to dispatcher
    rvx_pkg::lane_mask_t credit_ret;

    rvx_dispatch i_rvx_dispatch (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pkt     (in_pkt),
        .lane_push  (lane_push),
        .lane_pkt   (lane_pkt),
        .credit_ret (credit_ret)
    );

    // identical lanes, shared write data
    for (genvar g = 0; g < rvx_pkg::lane_count; g++) begin : g_lane
        rvx_alu_lane i_rvx_alu_lane (
            .clk       (clk),
            .arst_n    (arst_n),
            .push      (lane_push[g]),
            .pkt       (lane_pkt),
            .res_valid (lane_res_valid[g]),
            .res       (lane_res[g]),
            .pop       (lane_pop[g])
        );
    end

    rvx_collect i_rvx_collect (
        .clk            (clk),
        .arst_n         (arst_n),
        .lane_res_valid (lane_res_valid),
        .lane_res       (lane_res),
        .lane_pop       (lane_pop),
        .credit_ret     (credit_ret),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_pkt        (out_pkt)
    );

endmodule

//--- verification/rvx_cluster_assert.sv
`timescale 1ns/1ps

module rvx_cluster_assert (
    input logic clk,
    input logic arst_n,
    input logic out_valid,
    input logic out_ready,
    input rvx_pkg::result_pkt_t out_pkt,
    input rvx_pkg::lane_mask_t lane_push,
    input rvx_pkg::lane_mask_t credit_ret
);

    // dispatcher counters rebuilt from push and return pulses
    int credit_mirror [rvx_pkg::lane_count];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rvx_pkg::lane_count; i++) begin
                credit_mirror[i] <= rvx_pkg::lane_credits;
            end
        end else begin
            for (int i = 0; i < rvx_pkg::lane_count; i++) begin
                credit_mirror[i] <= credit_mirror[i] - int'(lane_push[i]) + int'(credit_ret[i]);
            end
        end
    end

    // stalled output holds its packet
    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_pkt)))
        else $error("out_pkt changed or dropped while out_ready was low");

    for (genvar g = 0; g < rvx_pkg::lane_count; g++) begin : g_lane_chk
        // push only into a lane with a free slot
        a_push_credit: assert property (@(posedge clk) disable iff (!arst_n)
            lane_push[g] |-> (credit_mirror[g] != 0))
            else $error("lane %0d pushed with zero credit", g);
        // returns never exceed what was spent
        a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
            (credit_mirror[g] >= 0) && (credit_mirror[g] <= rvx_pkg::lane_credits))
            else $error("lane %0d credit count out of range", g);
    end

endmodule

bind rvx_cluster_top rvx_cluster_assert i_rvx_cluster_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_pkt    (out_pkt),
    .lane_push  (lane_push),
    .credit_ret (credit_ret)
);

//--- verification/tb_rvx_cluster.sv
`timescale 1ns/1ps

module tb_rvx_cluster;

    ////////////////////////////////////////////////////////////
    // run length and modes
    ////////////////////////////////////////////////////////////

    localparam int n_r = 100;
    localparam int n_i = 100;
    localparam int n_ill = 40;
    localparam int n_mix = 400;
    // every lane full plus the output register
    localparam int bp_capacity = rvx_pkg::lane_count * rvx_pkg::lane_credits + 1;
    // one more waits at the input while full
    localparam int n_bp = bp_capacity + 1;
    localparam int bp_wait = 40;
    // cycles without an output before a drain gives up
    localparam int drain_idle_max = 16;
    localparam int cycle_limit = (n_r + n_i + n_ill + n_bp + n_mix) * 8 + 200;
    // out_ready modes
    localparam int ready_low = 0;
    localparam int ready_high = 1;
    localparam int ready_rand = 2;

    logic clk = 1'b0;
    logic arst_n;
    logic in_valid;
    logic in_ready;
    rvx_pkg::issue_pkt_t in_pkt;
    logic out_valid;
    logic out_ready;
    rvx_pkg::result_pkt_t out_pkt;

    int seed = 32'hdba1_1648;
    // separate stream for out_ready
    int ready_seed = 32'hdba1_1648 ^ 32'h0000_ffff;
    int ready_ctrl = ready_high;
    logic [rvx_pkg::tag_w-1:0] tag_seq = '0;
    rvx_pkg::result_pkt_t model_q [$];
    int accepted_cnt = 0;
    int received_cnt = 0;
    int checks = 0;
    int errors = 0;
    int cycles = 0;

    rvx_cluster_top i_rvx_cluster_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // rv32i alu rules on the raw instruction bits
    function automatic rvx_pkg::result_pkt_t expect_result(input rvx_pkg::issue_pkt_t p);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0] sh;
        logic is_r;
        logic is_i;
        rvx_pkg::result_pkt_t r;
        w = p.insn;
        a = p.rs1_val;
        is_r = (w[6:0] == rvx_pkg::opc_op);
        is_i = (w[6:0] == rvx_pkg::opc_op_imm);
        b = is_i ? {{20{w[31]}}, w[31:20]} : p.rs2_val;
        sh = b[4:0];
        r.tag = p.tag;
        r.illegal = !(is_r || is_i);
        r.value = '0;
        if (is_r || is_i) begin
            case (w[14:12])
                3'd0: r.value = (is_r && w[30]) ? a - b : a + b;
                3'd1: r.value = a << sh;
                3'd2: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: r.value = (a < b) ? 32'd1 : 32'd0;
                3'd4: r.value = a ^ b;
                // sign fill built from a mask of the vacated bits
                3'd5: r.value = w[30] ? ((a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh)))
                                      : a >> sh;
                3'd6: r.value = a | b;
                default: r.value = a & b;
            endcase
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // packet generators
    ////////////////////////////////////////////////////////////

    // small values hit slt and sign edges more often
    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        r = $random(seed);
        if (r[31:30] == 2'b00) begin
            r = {{28{r[3]}}, r[3:0]};
        end
        return r;
    endfunction

    function automatic rvx_pkg::issue_pkt_t make_pkt(input int kind);
        rvx_pkg::issue_pkt_t p;
        logic [31:0] r;
        logic [6:0] op;
        r = $random(seed);
        p.tag = tag_seq;
        tag_seq = tag_seq + 1'b1;
        p.rs1_val = rand_operand();
        p.rs2_val = rand_operand();
        // kind 2 is half illegal, kind 3 a weighted mix
        if (kind == 2) begin
            kind = r[31] ? 4 : 3;
        end
        if (kind == 3) begin
            kind = (r[30:28] < 3'd3) ? 0 : ((r[30:28] < 3'd6) ? 1 : 4);
        end
        if (kind == 0) begin
            p.insn.r.opcode = rvx_pkg::opc_op;
            p.insn.r.funct3 = r[2:0];
            p.insn.r.rd = r[7:3];
            p.insn.r.rs1 = r[12:8];
            p.insn.r.rs2 = r[17:13];
            // bit 30 only for add/sub and srl/sra
            p.insn.r.funct7 = (r[2:0] == 3'b000 || r[2:0] == 3'b101)
                              ? {1'b0, r[18], 5'b0} : 7'b0;
        end else if (kind == 1) begin
            p.insn.i.opcode = rvx_pkg::opc_op_imm;
            p.insn.i.funct3 = r[2:0];
            p.insn.i.rd = r[7:3];
            p.insn.i.rs1 = r[12:8];
            p.insn.i.imm12 = r[29:18];
            // shift forms carry shamt with bit 30 only for srai
            if (r[1:0] == 2'b01) begin
                p.insn.i.imm12 = {1'b0, r[2] & r[18], 5'b0, r[23:19]};
            end
        end else begin
            op = r[6:0];
            while (op == rvx_pkg::opc_op || op == rvx_pkg::opc_op_imm) begin
                op = op + 7'd1;
            end
            p.insn = {r[31:7], op};
        end
        return p;
    endfunction

    ////////////////////////////////////////////////////////////
    // driving and checking
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // called at posedge+2 and returns at posedge+2 after the transfer
    task automatic send_pkt(input rvx_pkg::issue_pkt_t p);
        logic took;
        took = 1'b0;
        in_pkt = p;
        in_valid = 1'b1;
        while (!took) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic run_stream(input int kind, input int count, input bit gaps);
        for (int n = 0; n < count; n++) begin
            if (gaps && (($random(seed) & 3) == 0)) begin
                @(posedge clk);
                #2;
            end
            send_pkt(make_pkt(kind));
        end
    endtask

    // returns once every expected result is out or outputs stop coming
    task automatic wait_drain();
        int last_rx;
        int idle;
        last_rx = received_cnt;
        idle = 0;
        while ((model_q.size() != 0 || out_valid) && idle < drain_idle_max) begin
            @(posedge clk);
            #2;
            if (received_cnt != last_rx) begin
                last_rx = received_cnt;
                idle = 0;
            end else begin
                idle++;
            end
        end
        checks++;
        assert (model_q.size() == 0) else begin
            $display("%0d expected results never came out", model_q.size());
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_start);
        $display("test %0d %s: done, %0d errors", num, name, errors - err_start);
    endtask

    // out_ready mode taken at the edge and driven 2 ns later
    initial begin
        int mode;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            mode = ready_ctrl;
            #2;
            if (mode == ready_rand) begin
                out_ready = (($random(ready_seed) & 1) != 0);
            end else begin
                out_ready = (mode == ready_high);
            end
        end
    end

    // transfers seen mid-cycle ahead of the edge that completes them
    always @(negedge clk) begin
        rvx_pkg::result_pkt_t exp;
        if (arst_n) begin
            if (in_valid && in_ready) begin
                model_q.push_back(expect_result(in_pkt));
                accepted_cnt++;
            end
            if (out_valid && out_ready) begin
                received_cnt++;
                assert (model_q.size() != 0) else begin
                    $display("output transfer with nothing outstanding, tag %h", out_pkt.tag);
                    errors++;
                end
                if (model_q.size() != 0) begin
                    exp = model_q.pop_front();
                    check_value("out_pkt.tag", 32'(out_pkt.tag), 32'(exp.tag));
                    check_value("out_pkt.value", out_pkt.value, exp.value);
                    check_value("out_pkt.illegal", 32'(out_pkt.illegal), 32'(exp.illegal));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int e0;
        int took_cnt;
        logic took;
        in_valid = 1'b0;
        in_pkt = '0;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        e0 = errors;
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("in_ready", 32'(in_ready), 32'd1);
        end_test(1, "reset state", e0);

        e0 = errors;
        run_stream(0, n_r, 1'b0);
        wait_drain();
        end_test(2, "r-type ops", e0);

        e0 = errors;
        run_stream(1, n_i, 1'b0);
        wait_drain();
        end_test(3, "i-type ops", e0);

        e0 = errors;
        run_stream(2, n_ill, 1'b0);
        wait_drain();
        end_test(4, "illegal opcodes", e0);

        // fill the cluster with the output stalled
        e0 = errors;
        took_cnt = 0;
        ready_ctrl = ready_low;
        @(posedge clk);
        #2;
        in_pkt = make_pkt(3);
        in_valid = 1'b1;
        repeat (bp_wait) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #2;
            if (took) begin
                took_cnt++;
                in_pkt = make_pkt(3);
            end
        end
        checks++;
        assert (took_cnt == bp_capacity) else begin
            $display("%0d packets accepted with out_ready low, capacity is %0d",
                     took_cnt, bp_capacity);
            errors++;
        end
        check_value("in_ready", 32'(in_ready), 32'd0);
        check_value("out_valid", 32'(out_valid), 32'd1);
        // pending packet must go in once results drain
        ready_ctrl = ready_high;
        in_valid = 1'b0;
        send_pkt(in_pkt);
        wait_drain();
        end_test(5, "back-pressure fill", e0);

        e0 = errors;
        ready_ctrl = ready_rand;
        run_stream(3, n_mix, 1'b1);
        ready_ctrl = ready_high;
        wait_drain();
        end_test(6, "mixed stream", e0);

        $display("checks %0d, errors %0d, packets in %0d, packets out %0d",
                 checks, errors, accepted_cnt, received_cnt);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- build.f
logic/rvx_pkg.sv
logic/rvx_dispatch.sv
logic/rvx_alu_lane.sv
logic/rvx_collect.sv
logic/rvx_cluster_top.sv
verification/rvx_cluster_assert.sv
verification/tb_rvx_cluster.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_rvx_cluster \
    -f build.f -o sim_rvx_cluster &&
./obj_dir/sim_rvx_cluster | tee /dev/stderr | grep -qx "sim passed" &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }
